//--- run.sh
#!/bin/sh
# build and run the tb_quan_post simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_quan_post \
  -f sim.f \
  -o tb_quan_post

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_quan_post

//--- sim.f
verilog/quan_pkg.sv
verilog/psum_accumulator.sv
verilog/sum_fifo.sv
verilog/bias_add_stage.sv
verilog/quan_post_top.sv
testbench/tb_quan_post.sv

//--- testbench/tb_quan_post.sv
`timescale 1ns/1ps

module tb_quan_post;

  typedef logic [quan_pkg::lane_num-1:0][quan_pkg::acc_width-1:0] lanes_t;

  // about 400 cycles of traffic plus a wide margin
  localparam int max_cycles = 2000;

  logic                 clk;
  logic                 rst_n;
  logic                 prod_valid;
  quan_pkg::prod_vec_t  prod;
  logic                 bias_valid;
  quan_pkg::bias_set_t  bias;
  logic                 out_valid;
  quan_pkg::acc_vec_u   out_vec;
  logic                 overflow;

  // model queues pair sums and biases in arrival order
  lanes_t                          sum_q[$];
  logic [quan_pkg::mode_width-1:0] mode_q[$];
  quan_pkg::bias_set_t             bias_q[$];
  lanes_t                          exp_q[$];
  lanes_t                          exp_v;

  int n_exp;
  int n_seen;
  int cycle_cnt;

  quan_post_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_valid (prod_valid),
    .prod       (prod),
    .bias_valid (bias_valid),
    .bias       (bias),
    .out_valid  (out_valid),
    .out_vec    (out_vec),
    .overflow   (overflow)
  );

  always #4 clk = ~clk;

  ////////////////////
  // reference model
  ////////////////////
  // adds one sign-extended product vector to the running sums
  function automatic lanes_t add_prod(
    input lanes_t                                         acc,
    input logic [quan_pkg::lane_num-1:0][quan_pkg::prod_width-1:0] lanes
  );
    lanes_t  r;
    shortint p16;
    int      p32;
    for (int i = 0; i < quan_pkg::lane_num; i++) begin
      p16  = lanes[i];
      p32  = p16;
      r[i] = acc[i] + p32;
    end
    return r;
  endfunction

  // expected out_vec for a finished sum, its mode and its bias set
  function automatic lanes_t ref_out(
    input lanes_t                          sum,
    input logic [quan_pkg::mode_width-1:0] mode,
    input quan_pkg::bias_set_t             b
  );
    lanes_t r;
    int     lo;
    int     hi;
    lo = b.bias_lo;
    hi = b.bias_hi;
    for (int i = 0; i < quan_pkg::lane_num; i++) begin
      if (mode == 4'd0) begin
        r[i] = (i < 8) ? sum[i] + lo : 32'd0;
      end else if (mode == 4'd1) begin
        r[i] = (i < 8) ? sum[i] + lo : sum[i] + hi;
      end else begin
        r[i] = 32'd0;
      end
    end
    return r;
  endfunction

  task automatic pair_outputs();
    lanes_t                          s;
    logic [quan_pkg::mode_width-1:0] m;
    quan_pkg::bias_set_t             b;
    while (sum_q.size() > 0 && bias_q.size() > 0) begin
      s = sum_q.pop_front();
      m = mode_q.pop_front();
      b = bias_q.pop_front();
      exp_q.push_back(ref_out(s, m, b));
      n_exp++;
    end
  endtask

  ////////////////////
  // checking
  ////////////////////
  task automatic check_val(input string name, input logic [511:0] got,
                           input logic [511:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "mismatch");
    end
  endtask

  // outputs are registered, so sample them away from the rising edge
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid rose with no expected output left");
        $display("tests failed");
        $fatal(1, "unexpected output");
      end else begin
        exp_v = exp_q.pop_front();
        check_val("out_vec", out_vec.lanes, exp_v);
        n_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: not all outputs arrived");
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // stimulus
  ////////////////////
  // mode of a group comes from its last strobe only
  task automatic send_group(input int n, input logic [3:0] mode, input bit extreme,
                            input bit keep);
    lanes_t              acc;
    quan_pkg::prod_vec_t p;
    acc = '0;
    for (int k = 0; k < n; k++) begin
      p.last = (k == n - 1);
      p.mode = p.last ? mode : 4'($urandom);
      for (int i = 0; i < quan_pkg::lane_num; i++) begin
        if (extreme) begin
          p.lanes[i] = ($urandom & 1) ? 16'h8000 : 16'h7fff;
        end else begin
          p.lanes[i] = 16'($urandom);
        end
      end
      acc = add_prod(acc, p.lanes);
      @(posedge clk);
      prod_valid <= 1'b1;
      prod       <= p;
    end
    @(posedge clk);
    prod_valid <= 1'b0;
    // a dropped group never reaches the model
    if (keep) begin
      sum_q.push_back(acc);
      mode_q.push_back(mode);
      pair_outputs();
    end
  endtask

  task automatic send_bias(input quan_pkg::bias_set_t b);
    @(posedge clk);
    bias_valid <= 1'b1;
    bias       <= b;
    bias_q.push_back(b);
    pair_outputs();
    @(posedge clk);
    bias_valid <= 1'b0;
    // idle bus carries other data than the pending set
    bias       <= ~b;
  endtask

  task automatic wait_outputs();
    while (n_seen < n_exp) begin
      @(posedge clk);
    end
  endtask

  function automatic quan_pkg::bias_set_t rand_bias(input bit negative);
    quan_pkg::bias_set_t b;
    b = 16'($urandom);
    if (negative) begin
      b.bias_hi[7] = 1'b1;
      b.bias_lo[7] = 1'b1;
    end
    return b;
  endfunction

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    prod_valid = 1'b0;
    prod       = '0;
    bias_valid = 1'b0;
    bias       = '0;
    n_exp      = 0;
    n_seen     = 0;
    cycle_cnt  = 0;
    void'($urandom(46922));

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // mode 0 with a single channel
    for (int g = 0; g < 6; g++) begin
      send_group(1 + int'($urandom % 5), 4'd0, 1'b0, 1'b1);
      send_bias(rand_bias(1'b0));
      wait_outputs();
    end

    // mode 1 with negative bias and extreme products
    for (int g = 0; g < 6; g++) begin
      send_group(1 + int'($urandom % 5), 4'd1, 1'b1, 1'b1);
      send_bias(rand_bias(1'b1));
      wait_outputs();
    end

    // unsupported modes still give out_valid
    for (int m = 2; m < 16; m++) begin
      send_group(1 + int'($urandom % 5), 4'(m), 1'b0, 1'b1);
      send_bias(rand_bias(1'b0));
      wait_outputs();
    end

    // bias waits as pending until the sum lands
    for (int g = 0; g < 3; g++) begin
      send_bias(rand_bias(g[0]));
      send_group(1 + int'($urandom % 5), 4'(g % 2), 1'b0, 1'b1);
      wait_outputs();
    end

    // fill all four entries, then drain
    for (int g = 0; g < 4; g++) begin
      send_group(1 + int'($urandom % 5), 4'(g % 2), 1'b0, 1'b1);
    end
    repeat (3) @(posedge clk);
    check_val("overflow", 512'(overflow), 512'(0));
    for (int g = 0; g < 4; g++) begin
      send_bias(rand_bias(1'b0));
    end
    wait_outputs();

    // fifth group hits a full FIFO and is lost
    for (int g = 0; g < 4; g++) begin
      send_group(1 + int'($urandom % 5), 4'(g % 2), 1'b0, 1'b1);
    end
    send_group(2, 4'd1, 1'b0, 1'b0);
    repeat (3) @(posedge clk);
    check_val("overflow", 512'(overflow), 512'(1));
    for (int g = 0; g < 4; g++) begin
      send_bias(rand_bias(1'b1));
    end
    wait_outputs();

    repeat (5) @(posedge clk);
    check_val("expected queue size", 512'(exp_q.size()), 512'(0));
    check_val("overflow", 512'(overflow), 512'(1));
    $display("all tests passed");
    $finish;
  end

endmodule

//--- verilog/bias_add_stage.sv
`timescale 1ns/1ps

module bias_add_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  bias_valid,
  input  quan_pkg::bias_set_t   bias,
  input  quan_pkg::sum_entry_t  head,
  input  logic                  empty,
  output logic                  pop,
  output logic                  out_valid,
  output quan_pkg::acc_vec_u    out_vec
);

  logic                 pend_valid;
  quan_pkg::bias_set_t  pend_bias;
  quan_pkg::bias_set_t  cur_bias;
  quan_pkg::acc_vec_u   biased;

  // adds one sign-extended bias byte to every lane of a channel
  function automatic quan_pkg::chan_vec_t add_bias(
    input quan_pkg::chan_vec_t              v,
    input logic [quan_pkg::bias_width-1:0]  b
  );
    quan_pkg::chan_vec_t              r;
    logic [quan_pkg::acc_width-1:0]   b_ext;
    b_ext = {{(quan_pkg::acc_width - quan_pkg::bias_width){b[quan_pkg::bias_width-1]}}, b};
    for (int i = 0; i < quan_pkg::chan_lane_num; i++) begin
      r[i] = v[i] + b_ext;
    end
    return r;
  endfunction

  ////////////////////
  // pairing
  ////////////////////
  // pending set has priority; a new strobe never overlaps one
  assign cur_bias = pend_valid ? pend_bias : bias;
  assign pop      = (bias_valid || pend_valid) && !empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
    end else if (pop) begin
      pend_valid <= 1'b0;
    end else if (bias_valid) begin
      pend_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (bias_valid && !pend_valid) begin
      pend_bias <= bias;
    end
  end

  ////////////////////
  // bias add per mode
  ////////////////////
  always_comb begin
    biased = '0;
    case (head.mode)
      quan_pkg::mode_88: begin
        // single channel, upper lanes stay zero
        biased.chan.ch0 = add_bias(head.sum.chan.ch0, cur_bias.bias_lo);
      end
      quan_pkg::mode_18: begin
        biased.chan.ch0 = add_bias(head.sum.chan.ch0, cur_bias.bias_lo);
        biased.chan.ch1 = add_bias(head.sum.chan.ch1, cur_bias.bias_hi);
      end
      default: begin
        biased = '0;
      end
    endcase
  end

  // output register, one cycle after pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      out_vec <= biased;
    end
  end

endmodule

//--- verilog/psum_accumulator.sv
`timescale 1ns/1ps

module psum_accumulator (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  prod_valid,
  input  quan_pkg::prod_vec_t   prod,
  output logic                  sum_valid,
  output quan_pkg::sum_entry_t  sum_entry
);

  // running per-lane sums of the current group
  logic [quan_pkg::lane_num-1:0][quan_pkg::acc_width-1:0] run_sum;
  logic [quan_pkg::lane_num-1:0][quan_pkg::acc_width-1:0] next_sum;
  logic                                                   group_done;

  assign group_done = prod_valid && prod.last;

  ////////////////////
  // lane adders
  ////////////////////
  always_comb begin
    for (int i = 0; i < quan_pkg::lane_num; i++) begin
      // sign-extend product, sum wraps mod 2^32
      next_sum[i] = run_sum[i] +
                    {{(quan_pkg::acc_width - quan_pkg::prod_width)
                      {prod.lanes[i][quan_pkg::prod_width-1]}},
                     prod.lanes[i]};
    end
  end

  ////////////////////
  // group state
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_sum   <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= group_done;
      if (prod_valid) begin
        // next group starts from zero
        if (prod.last) begin
          run_sum <= '0;
        end else begin
          run_sum <= next_sum;
        end
      end
    end
  end

  // finished vector, includes the last product
  always_ff @(posedge clk) begin
    if (group_done) begin
      sum_entry.sum.lanes <= next_sum;
      sum_entry.mode      <= prod.mode;
    end
  end

endmodule

//--- verilog/quan_pkg.sv
package quan_pkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int lane_num      = 16;
  localparam int chan_lane_num = 8;
  localparam int prod_width    = 16;
  localparam int acc_width     = 32;
  localparam int bias_width    = 8;
  localparam int mode_width    = 4;

  localparam int fifo_depth     = 4;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  localparam int fifo_cnt_width = fifo_ptr_width + 1;
  localparam logic [fifo_cnt_width-1:0] fifo_full_cnt = fifo_cnt_width'(fifo_depth);

  // precision modes
  localparam logic [mode_width-1:0] mode_88 = 4'd0;
  localparam logic [mode_width-1:0] mode_18 = 4'd1;

  ////////////////////
  // vector types
  ////////////////////
  typedef logic [chan_lane_num-1:0][acc_width-1:0] chan_vec_t;

  typedef struct packed {
    logic [lane_num-1:0][prod_width-1:0] lanes;
    logic [mode_width-1:0]               mode;
    logic                                last;
  } prod_vec_t;

  // ch0 sits in the low half, so it lines up with lanes 0..7
  typedef struct packed {
    chan_vec_t ch1;
    chan_vec_t ch0;
  } acc_chan_t;

  typedef union packed {
    logic [lane_num-1:0][acc_width-1:0] lanes;
    acc_chan_t                          chan;
  } acc_vec_u;

  typedef struct packed {
    acc_vec_u              sum;
    logic [mode_width-1:0] mode;
  } sum_entry_t;

  typedef struct packed {
    logic signed [bias_width-1:0] bias_hi;
    logic signed [bias_width-1:0] bias_lo;
  } bias_set_t;

endpackage

//--- verilog/quan_post_top.sv
`timescale 1ns/1ps

module quan_post_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 prod_valid,
  input  quan_pkg::prod_vec_t  prod,
  input  logic                 bias_valid,
  input  quan_pkg::bias_set_t  bias,
  output logic                 out_valid,
  output quan_pkg::acc_vec_u   out_vec,
  output logic                 overflow
);

  // accumulator to fifo
  logic                  sum_valid;
  quan_pkg::sum_entry_t  sum_entry;

  // fifo to bias adder
  logic                  pop;
  logic                  empty;
  quan_pkg::sum_entry_t  head;

  psum_accumulator u_acc (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_valid (prod_valid),
    .prod       (prod),
    .sum_valid  (sum_valid),
    .sum_entry  (sum_entry)
  );

  sum_fifo u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (sum_valid),
    .wr_data  (sum_entry),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .overflow (overflow)
  );

  bias_add_stage u_bias (
    .clk        (clk),
    .rst_n      (rst_n),
    .bias_valid (bias_valid),
    .bias       (bias),
    .head       (head),
    .empty      (empty),
    .pop        (pop),
    .out_valid  (out_valid),
    .out_vec    (out_vec)
  );

endmodule

//--- verilog/sum_fifo.sv
`timescale 1ns/1ps

module sum_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr,
  input  quan_pkg::sum_entry_t  wr_data,
  input  logic                  pop,
  output quan_pkg::sum_entry_t  head,
  output logic                  empty,
  output logic                  overflow
);

  quan_pkg::sum_entry_t mem [quan_pkg::fifo_depth];

  logic [quan_pkg::fifo_ptr_width-1:0] rd_ptr;
  logic [quan_pkg::fifo_ptr_width-1:0] wr_ptr;
  logic [quan_pkg::fifo_cnt_width-1:0] count;
  logic                                full;
  logic                                do_pop;
  logic                                do_wr;

  assign full  = (count == quan_pkg::fifo_full_cnt);
  assign empty = (count == '0);
  assign head  = mem[rd_ptr];

  // a pop frees the slot in the same cycle, so a full write can still land
  assign do_pop = pop && !empty;
  assign do_wr  = wr && (!full || do_pop);

  ////////////////////
  // pointers
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_pop) begin
        count <= count + 1'b1;
      end else if (!do_wr && do_pop) begin
        count <= count - 1'b1;
      end
      // sticky until reset
      if (wr && !do_wr) begin
        overflow <= 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule
